// File: list.f
+incdir+.
mem_frontend_pkg.sv
mem_port_arbiter.sv
fetch_decode_stage.sv
retire_status.sv
core_mem_frontend.sv
tb_core_mem_frontend.sv

// File: Bender.yml
package:
  name: core_mem_frontend

sources:
  - include_dirs:
      - .
    files:
      - mem_frontend_pkg.sv
      - mem_port_arbiter.sv
      - fetch_decode_stage.sv
      - retire_status.sv
      - core_mem_frontend.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_core_mem_frontend.sv

// File: tb_core_mem_frontend.sv
// testbench for the memory front end
// reference model of owner chain, fetch/decode register and retire status

`default_nettype none

`include "mem_frontend_macros.svh"

module tb_core_mem_frontend
    import mem_frontend_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    typedef struct packed {
        mem_req_t                 mem_req;
        logic [`MEM_TAG_BITS-1:0] fetch_tag;
        logic [`MEM_TAG_BITS-1:0] data_tag;
        logic                     stall;
        logic                     enable;
        fetch_packet_t            decode;
        commit_t                  commit;
        logic [3:0]               count;
        exception_e               error;
    } outputs_t;

    logic clock, reset, halt_confirm, dispatch_ok, retire_stall, flush;
    logic fetch_stall, fetch_enable, halted;
    logic [`XLEN-1:0] fetch_addr;
    logic [`MEM_TAG_BITS-1:0] fetch_rsp_tag, data_rsp_tag, mem_rsp_tag_out;
    logic [`MEM_DATA_BITS-1:0] mem_rsp_data;
    logic [3:0] completed_insts;
    mem_rsp_t mem_rsp;
    mem_req_t mem_req, data_req;
    fetch_packet_t fetch_packet, decode_packet, sample_packet;
    retire_t retire;
    commit_t commit;
    exception_e error_status;
    outputs_t expected;
    integer seed;
    int error_count, edges;

    // model state mirrors the three-flag owner chain
    logic own_q, own_d1, own_d2, ref_halted;
    fetch_packet_t ref_decode;

    core_mem_frontend i_dut (.*);

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    //////////////////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////////////////

    always @(posedge clock or posedge reset) begin
        if (reset) begin
            {own_q, own_d1, own_d2, ref_halted} <= '0;
            ref_decode <= '0;
        end else begin
            own_q  <= (data_req.cmd != BUS_NONE);
            own_d1 <= own_q;
            own_d2 <= own_d1;
            if (retire.valid && retire.halt)
                ref_halted <= 1'b1;
            if (flush || ref_halted)
                ref_decode <= '0;
            else if (dispatch_ok)
                ref_decode <= fetch_packet;
        end
    end

    function automatic outputs_t reference_outputs();
        outputs_t o;
        o = '0;
        // registered data owner takes the bus over the fetch load
        if (own_q) begin
            o.mem_req = data_req;
        end else begin
            o.mem_req.cmd  = BUS_LOAD;
            o.mem_req.addr = fetch_addr;
            o.mem_req.size = DOUBLE;
        end
        // tag only where oldest and newest flag agree
        if (own_d2 && own_q)
            o.data_tag = mem_rsp.response;
        if (!own_d2 && !own_q)
            o.fetch_tag = mem_rsp.response;
        o.stall  = own_d1;
        o.enable = dispatch_ok && !own_d1 && !retire_stall && !ref_halted;
        o.decode = ref_decode;
        o.commit = {retire.valid, retire.dest_idx, retire.value, retire.npc};
        o.count  = retire.valid ? 4'd1 : 4'd0;
        if (retire.illegal)
            o.error = ILLEGAL_INST;
        else if (ref_halted && halt_confirm)
            o.error = HALTED_ON_WFI;
        else
            o.error = NO_ERROR;
        return o;
    endfunction

    //////////////////////////////////////////////////////////////
    // checking
    //////////////////////////////////////////////////////////////

    task automatic stop_with_failure(input string what);
        $display("%s", what);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [127:0] actual,
                               input logic [127:0] wanted);
        if (actual !== wanted) begin
            error_count++;
            stop_with_failure($sformatf("Error at %0t ns: %s is %h, expected %h",
                                        $time, name, actual, wanted));
        end
    endtask

    // sample late in the high phase once everything has settled
    initial begin
        forever begin
            @(posedge clock);
            #4;
            expected = reference_outputs();
            check_value("mem_req", mem_req, expected.mem_req);
            check_value("fetch_rsp_tag", fetch_rsp_tag, expected.fetch_tag);
            check_value("data_rsp_tag", data_rsp_tag, expected.data_tag);
            check_value("fetch_stall", fetch_stall, expected.stall);
            check_value("fetch_enable", fetch_enable, expected.enable);
            check_value("decode_packet", decode_packet, expected.decode);
            check_value("halted", halted, ref_halted);
            check_value("commit", commit, expected.commit);
            check_value("completed_insts", completed_insts, expected.count);
            check_value("error_status", error_status, expected.error);
            check_value("mem_rsp_data", mem_rsp_data, mem_rsp.data);
            check_value("mem_rsp_tag_out", mem_rsp_tag_out, mem_rsp.tag);
        end
    end

    // counts rising edges until the picked signal reaches level
    task automatic edges_until(input int which, input string what, input logic level,
                               input int limit, output int count);
        logic now;
        count = 0;
        now   = ~level;
        while (now !== level) begin
            @(posedge clock);
            #1;
            count++;
            case (which)
                0:       now = (mem_req === data_req);
                1:       now = fetch_stall;
                default: now = halted;
            endcase
            if (now !== level && count >= limit)
                stop_with_failure($sformatf("timed out after %0d edges waiting for %s",
                                            limit, what));
        end
    endtask

    //////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////

    task automatic drive_random_cycle(input logic with_traffic, input logic with_controls);
        int pick;
        @(negedge clock);
        pick = $unsigned($random(seed)) % 4;
        if (with_traffic) begin
            data_req.cmd  = (pick == 2) ? BUS_LOAD : (pick == 3) ? BUS_STORE : BUS_NONE;
            data_req.addr = $random(seed);
            data_req.data = {$random(seed), $random(seed)};
            data_req.size = mem_size_e'($unsigned($random(seed)) % 4);
        end
        mem_rsp.response = $unsigned($random(seed)) % 16;
        mem_rsp.data     = {$random(seed), $random(seed)};
        mem_rsp.tag      = $unsigned($random(seed)) % 16;
        fetch_addr       = $random(seed);
        fetch_packet     = {$random(seed), $random(seed), $random(seed), $random(seed)};
        if (with_controls) begin
            dispatch_ok    = $random(seed);
            retire_stall   = ($unsigned($random(seed)) % 4) == 0;
            flush          = ($unsigned($random(seed)) % 8) == 0;
            retire         = {$random(seed), $random(seed), $random(seed)};
            // halt is saved for the last phase
            retire.halt    = 1'b0;
            retire.illegal = ($unsigned($random(seed)) % 8) == 0;
        end
    endtask

    initial begin
        seed = 37;
        error_count = 0;
        reset = 1'b1;
        {halt_confirm, dispatch_ok, retire_stall, flush} = '0;
        fetch_addr = '0;
        mem_rsp = '0;
        data_req = '0;
        fetch_packet = '0;
        retire = '0;
        repeat (4) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        // idle fetch with no data command
        repeat (8) drive_random_cycle(1'b0, 1'b0);
        #1;
        check_value("mem_req.cmd", mem_req.cmd, BUS_LOAD);
        check_value("mem_req.size", mem_req.size, DOUBLE);
        check_value("fetch_rsp_tag", fetch_rsp_tag, mem_rsp.response);

        // data takeover and release
        @(negedge clock);
        data_req = {BUS_STORE, 32'h0000_1008, 64'hdead_beef_0123_4567, WORD};
        #1;
        check_value("mem_req.cmd before takeover", mem_req.cmd, BUS_LOAD);
        edges_until(0, "data request on mem_req", 1'b1, 8, edges);
        check_value("edges to data owner", edges, 1);
        check_value("fetch_stall at data owner", fetch_stall, 1'b0);
        edges_until(1, "fetch_stall rise", 1'b1, 8, edges);
        check_value("edges to fetch_stall rise", edges + 1, 2);
        repeat (3) @(negedge clock);
        data_req.cmd = BUS_NONE;
        #1;
        check_value("mem_req.cmd before release", mem_req.cmd, BUS_NONE);
        edges_until(0, "fetch load on mem_req", 1'b0, 8, edges);
        check_value("edges to fetch owner", edges, 1);
        check_value("fetch_stall at fetch owner", fetch_stall, 1'b1);
        edges_until(1, "fetch_stall fall", 1'b0, 8, edges);
        check_value("edges to fetch_stall fall", edges + 1, 2);

        // routing under random traffic
        repeat (300) drive_random_cycle(1'b1, 1'b0);

        // fetch/decode register load, hold and flush
        @(negedge clock);
        data_req.cmd = BUS_NONE;
        dispatch_ok = 1'b1;
        sample_packet = {1'b1, 32'h0000_0513, 32'h0000_0100, 32'h0000_0104};
        fetch_packet = sample_packet;
        #1;
        check_value("decode_packet before load", decode_packet, '0);
        @(negedge clock);
        check_value("decode_packet after load", decode_packet, sample_packet);
        dispatch_ok = 1'b0;
        fetch_packet = '0;
        @(negedge clock);
        check_value("decode_packet on hold", decode_packet, sample_packet);
        flush = 1'b1;
        #1;
        check_value("decode_packet before flush", decode_packet, sample_packet);
        @(negedge clock);
        check_value("decode_packet after flush", decode_packet, '0);
        flush = 1'b0;
        repeat (300) drive_random_cycle(1'b1, 1'b1);

        // retire strobe then illegal then halt
        @(negedge clock);
        {data_req.cmd, dispatch_ok, retire_stall, flush} = '0;
        retire = {1'b1, 5'd7, 32'h1234_5678, 32'h0000_2000, 1'b0, 1'b0};
        #1;
        check_value("commit.wr_data", commit.wr_data, 32'h1234_5678);
        check_value("completed_insts", completed_insts, 4'd1);
        @(negedge clock);
        retire.illegal = 1'b1;
        #1;
        check_value("error_status", error_status, ILLEGAL_INST);
        @(negedge clock);
        retire = {1'b1, 5'd0, 32'h0, 32'h0000_2004, 1'b1, 1'b0};
        dispatch_ok = 1'b1;
        fetch_packet = sample_packet;
        #1;
        check_value("halted before edge", halted, 1'b0);
        edges_until(2, "halted", 1'b1, 4, edges);
        check_value("edges to halted", edges, 1);
        @(negedge clock);
        retire = '0;
        repeat (4) @(negedge clock);
        check_value("fetch_enable after halt", fetch_enable, 1'b0);
        check_value("decode_packet after halt", decode_packet, '0);
        halt_confirm = 1'b1;
        #1;
        check_value("error_status", error_status, HALTED_ON_WFI);
        repeat (4) @(negedge clock);

        if (error_count == 0) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            $display("Result: FAILED");
            $fatal(1, "checks failed");
        end
    end

endmodule

`default_nettype wire

// File: core_mem_frontend.sv
// memory front end top level
// port arbiter, fetch/decode stage and retire status, wired together

`default_nettype none

`include "mem_frontend_macros.svh"

module core_mem_frontend
    import mem_frontend_pkg::*;
(
    input  wire logic                      clock,
    input  wire logic                      reset,

    // memory
    input  mem_rsp_t                       mem_rsp,
    output mem_req_t                       mem_req,

    // instruction cache
    input  wire logic [`XLEN-1:0]          fetch_addr,
    output logic      [`MEM_TAG_BITS-1:0]  fetch_rsp_tag,

    // data cache
    input  mem_req_t                       data_req,
    output logic      [`MEM_TAG_BITS-1:0]  data_rsp_tag,
    input  wire logic                      halt_confirm,

    // shared to both caches
    output logic      [`MEM_DATA_BITS-1:0] mem_rsp_data,
    output logic      [`MEM_TAG_BITS-1:0]  mem_rsp_tag_out,

    // fetch and decode
    input  fetch_packet_t                  fetch_packet,
    input  wire logic                      dispatch_ok,
    input  wire logic                      retire_stall,
    input  wire logic                      flush,
    output logic                           fetch_stall,
    output logic                           fetch_enable,
    output fetch_packet_t                  decode_packet,

    // retire
    input  retire_t                        retire,
    output logic                           halted,
    output commit_t                        commit,
    output logic      [3:0]                completed_insts,
    output exception_e                     error_status
);

    // data and reply tag go to both clients, each filters by its own tag
    assign mem_rsp_data    = mem_rsp.data;
    assign mem_rsp_tag_out = mem_rsp.tag;

    mem_port_arbiter i_arbiter (
        .clock         (clock),
        .reset         (reset),
        .fetch_addr    (fetch_addr),
        .data_req      (data_req),
        .mem_rsp       (mem_rsp),
        .mem_req       (mem_req),
        .fetch_rsp_tag (fetch_rsp_tag),
        .data_rsp_tag  (data_rsp_tag),
        .fetch_stall   (fetch_stall)
    );

    // stall from the arbiter, halt from retire
    fetch_decode_stage i_fetch_decode (
        .clock         (clock),
        .reset         (reset),
        .fetch_packet  (fetch_packet),
        .dispatch_ok   (dispatch_ok),
        .fetch_stall   (fetch_stall),
        .retire_stall  (retire_stall),
        .flush         (flush),
        .halted        (halted),
        .fetch_enable  (fetch_enable),
        .decode_packet (decode_packet)
    );

    retire_status i_retire_status (
        .clock           (clock),
        .reset           (reset),
        .retire          (retire),
        .halt_confirm    (halt_confirm),
        .halted          (halted),
        .commit          (commit),
        .completed_insts (completed_insts),
        .error_status    (error_status)
    );

endmodule

`default_nettype wire

// File: retire_status.sv
// retire side status
// sticky halt latch, commit report, completed count, error status

`default_nettype none

module retire_status
    import mem_frontend_pkg::*;
(
    input  wire logic  clock,
    input  wire logic  reset,

    // one retiring instruction, strobe
    input  retire_t    retire,
    // data cache has written back after halt
    input  wire logic  halt_confirm,

    output logic       halted,
    output commit_t    commit,
    output logic [3:0] completed_insts,
    output exception_e error_status
);

    ////////////////////////////////////////////////////////////
    // halt latch
    ////////////////////////////////////////////////////////////

    // set one edge after the halt retires
    // only reset brings it back down
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            halted <= 1'b0;
        end else if (retire.valid && retire.halt) begin
            halted <= 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // commit report
    ////////////////////////////////////////////////////////////

    // straight from the retire strobe, same cycle
    assign commit.wr_en   = retire.valid;
    assign commit.wr_idx  = retire.dest_idx;
    assign commit.wr_data = retire.value;
    assign commit.npc     = retire.npc;

    // at most one instruction retires per cycle
    assign completed_insts = retire.valid ? 4'd1 : 4'd0;

    ////////////////////////////////////////////////////////////
    // error status
    ////////////////////////////////////////////////////////////

    // illegal first, then halt once memory is drained
    always_comb begin
        if (retire.illegal) begin
            error_status = ILLEGAL_INST;
        end else if (halted && halt_confirm) begin
            error_status = HALTED_ON_WFI;
        end else begin
            error_status = NO_ERROR;
        end
    end

    ////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////

    a_halt_sticky : assert property (
        @(posedge clock) disable iff (reset)
        halted |=> halted
    );

endmodule

`default_nettype wire

// File: fetch_decode_stage.sv
// fetch enable gating and fetch/decode pipeline register
// flush and halt clear the register ahead of a load

`default_nettype none

module fetch_decode_stage
    import mem_frontend_pkg::*;
(
    input  wire logic    clock,
    input  wire logic    reset,

    input  fetch_packet_t fetch_packet,

    // core and arbiter controls, all levels
    input  wire logic    dispatch_ok,
    input  wire logic    fetch_stall,
    input  wire logic    retire_stall,
    input  wire logic    flush,
    input  wire logic    halted,

    output logic         fetch_enable,
    output fetch_packet_t decode_packet
);

    ////////////////////////////////////////////////////////////
    // fetch gate
    ////////////////////////////////////////////////////////////

    // needs dispatch room, the memory port, no retire stall
    // and a core that is still running
    assign fetch_enable = dispatch_ok && !fetch_stall && !retire_stall && !halted;

    ////////////////////////////////////////////////////////////
    // fetch/decode register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            decode_packet <= '0;
        end else if (flush || halted) begin
            // squash whatever sits in decode
            decode_packet <= '0;
        end else if (dispatch_ok) begin
            decode_packet <= fetch_packet;
        end
        // no dispatch room, hold for decode
    end

    ////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////

    // decode must see the same packet until it can dispatch
    a_hold_no_dispatch : assert property (
        @(posedge clock) disable iff (reset)
        (!flush && !halted && !dispatch_ok) |=> $stable(decode_packet)
    );

endmodule

`default_nettype wire

// File: mem_port_arbiter.sv
// shared memory port arbiter
// data over fetch bus select, three stage ownership chain, response tag routing

`default_nettype none

`include "mem_frontend_macros.svh"

module mem_port_arbiter
    import mem_frontend_pkg::*;
(
    input  wire logic                     clock,
    input  wire logic                     reset,

    // clients
    input  wire logic [`XLEN-1:0]         fetch_addr,
    input  mem_req_t                      data_req,

    // memory side
    input  mem_rsp_t                      mem_rsp,
    output mem_req_t                      mem_req,

    // routed response tags
    output logic      [`MEM_TAG_BITS-1:0] fetch_rsp_tag,
    output logic      [`MEM_TAG_BITS-1:0] data_rsp_tag,

    output logic                          fetch_stall
);

    ////////////////////////////////////////////////////////////
    // ownership chain
    ////////////////////////////////////////////////////////////

    // data side asks for the port this cycle
    logic data_wants;

    // q picks the bus source
    // d1 stalls fetch, d2 steers responses
    logic data_owner_q;
    logic data_owner_d1;
    logic data_owner_d2;

    assign data_wants = (data_req.cmd != BUS_NONE);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            data_owner_q  <= 1'b0;
            data_owner_d1 <= 1'b0;
            data_owner_d2 <= 1'b0;
        end else begin
            data_owner_q  <= data_wants;
            data_owner_d1 <= data_owner_q;
            data_owner_d2 <= data_owner_d1;
        end
    end

    ////////////////////////////////////////////////////////////
    // bus select
    ////////////////////////////////////////////////////////////

    // data request wins once registered
    // fetch load of a full double word is the default
    always_comb begin
        if (data_owner_q) begin
            mem_req = data_req;
        end else begin
            mem_req.cmd  = BUS_LOAD;
            mem_req.addr = fetch_addr;
            mem_req.data = '0;
            mem_req.size = DOUBLE;
        end
    end

    // hold fetch off while the data side owns the port
    assign fetch_stall = data_owner_d1;

    ////////////////////////////////////////////////////////////
    // response routing
    ////////////////////////////////////////////////////////////

    // oldest flag names the client whose request the tag answers
    // newest flag must agree, otherwise the owner has already changed
    // and the tag is dropped for both
    always_comb begin
        fetch_rsp_tag = '0;
        data_rsp_tag  = '0;
        if (data_owner_d2) begin
            if (data_owner_q) begin
                data_rsp_tag = mem_rsp.response;
            end
        end else begin
            if (!data_owner_q) begin
                fetch_rsp_tag = mem_rsp.response;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////

    // one memory transaction can only belong to one client
    a_one_rsp_owner : assert property (
        @(posedge clock) disable iff (reset)
        !((fetch_rsp_tag != '0) && (data_rsp_tag != '0))
    );

endmodule

`default_nettype wire

// File: mem_frontend_pkg.sv
// shared types for the memory front end
// bus command/size enums, request and reply structs, fetch and retire packets

`default_nettype none

`include "mem_frontend_macros.svh"

package mem_frontend_pkg;

    ////////////////////////////////////////////////////////////
    // memory bus
    ////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        BUS_NONE  = 2'h0,
        BUS_LOAD  = 2'h1,
        BUS_STORE = 2'h2
    } mem_cmd_e;

    typedef enum logic [1:0] {
        BYTE   = 2'h0,
        HALF   = 2'h1,
        WORD   = 2'h2,
        DOUBLE = 2'h3
    } mem_size_e;

    // one request on the shared port
    typedef struct packed {
        mem_cmd_e                  cmd;
        logic [`XLEN-1:0]          addr;
        logic [`MEM_DATA_BITS-1:0] data;
        mem_size_e                 size;
    } mem_req_t;

    // response = tag given to the accepted request, tag = tag of returning data
    typedef struct packed {
        logic [`MEM_TAG_BITS-1:0]  response;
        logic [`MEM_DATA_BITS-1:0] data;
        logic [`MEM_TAG_BITS-1:0]  tag;
    } mem_rsp_t;

    ////////////////////////////////////////////////////////////
    // pipeline packets
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        logic                  valid;
        logic [`INST_BITS-1:0] inst;
        logic [`XLEN-1:0]      pc;
        logic [`XLEN-1:0]      npc;
    } fetch_packet_t;

    // strobe from the retire stage, one instruction per cycle
    typedef struct packed {
        logic                     valid;
        logic [`REG_IDX_BITS-1:0] dest_idx;
        logic [`XLEN-1:0]         value;
        logic [`XLEN-1:0]         npc;
        logic                     halt;
        logic                     illegal;
    } retire_t;

    typedef struct packed {
        logic                     wr_en;
        logic [`REG_IDX_BITS-1:0] wr_idx;
        logic [`XLEN-1:0]         wr_data;
        logic [`XLEN-1:0]         npc;
    } commit_t;

    typedef enum logic [3:0] {
        NO_ERROR      = 4'h0,
        ILLEGAL_INST  = 4'h2,
        HALTED_ON_WFI = 4'hb
    } exception_e;

endpackage

`default_nettype wire

// File: mem_frontend_macros.svh
// width macros for the memory front end
// bus, tag, register index and instruction widths

`ifndef MEM_FRONTEND_MACROS_SVH
`define MEM_FRONTEND_MACROS_SVH

////////////////////////////////////////////////////////////
// address and data widths
////////////////////////////////////////////////////////////

// address and architectural register width
`define XLEN 32

// memory bus data, one double word
`define MEM_DATA_BITS 64

// response tag and reply tag, zero means none
`define MEM_TAG_BITS 4

////////////////////////////////////////////////////////////
// core side widths
////////////////////////////////////////////////////////////

// 32 architectural registers
`define REG_IDX_BITS 5
`define INST_BITS 32

`endif
